/* Makefile */
# Verilator build and run of the debug control processor testbench

VERILATOR ?= verilator
TOP       ?= tb_dcp
FLAGS     ?= --binary --timing --assert
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

# pass only if the run prints the pass message
sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f tb.f
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* hdl/dcp_cmd_pkg.sv */
`default_nettype none

package dcp_cmd_pkg;

    ////////////////////////////////////////////////////////////
    // command characters
    ////////////////////////////////////////////////////////////

    // values are the ascii codes seen on d_rx
    typedef enum logic [7:0] {
        CMD_D = 8'h44,
        CMD_P = 8'h50
    } cmd_e;

    ////////////////////////////////////////////////////////////
    // dispatcher fsm
    ////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        // idle before the next command
        INIT    = 3'd0,
        // read the command character
        REQ_1ST = 3'd1,
        // print pc and newline
        RUN_P   = 3'd2,
        // kick off the dump engine
        RUN_D   = 3'd3,
        // dump engine owns scan and print
        WAIT    = 3'd4
    } disp_state_e;

endpackage

`default_nettype wire

/* hdl/dcp_dump.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dcp_cfg.svh"

module dcp_dump (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    start,
    dcp_io_if.client               io,
    output logic [`DCP_DATA_W-1:0] addr,
    input  wire [`DCP_DATA_W-1:0]  dout_dm,
    output logic                   finish
);

    localparam int CNT_W = $clog2(`DCP_DUMP_WORDS + 1);

    typedef enum logic [3:0] {
        D_IDLE,
        D_REQ_A,
        D_WAIT_A,
        D_READ,
        D_P_HEX,
        D_W_HEX,
        D_P_NL,
        D_W_NL,
        D_DONE
    } dump_state_e;

    dump_state_e            state;
    logic [`DCP_DATA_W-1:0] cur_addr;
    logic [CNT_W-1:0]       cnt;
    logic                   pend_rx;
    logic                   pend_tx;

    ////////////////////////////////////////////////////////////
    // sequencer
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state    <= D_IDLE;
            cur_addr <= '0;
            cnt      <= '0;
        end
        else
        begin
            case (state)
                D_IDLE:   if (start) state <= D_REQ_A;
                D_REQ_A:  state <= D_WAIT_A;
                D_WAIT_A:
                    if (io.ack_rx)
                    begin
                        cur_addr <= io.din_rx;
                        cnt      <= '0;
                        state    <= D_READ;
                    end
                // memory answers one cycle after addr
                D_READ:   state <= D_P_HEX;
                D_P_HEX:  state <= D_W_HEX;
                D_W_HEX:  if (io.ack_tx) state <= D_P_NL;
                D_P_NL:   state <= D_W_NL;
                D_W_NL:
                    if (io.ack_tx)
                    begin
                        if (cnt == CNT_W'(`DCP_DUMP_WORDS - 1))
                            state <= D_DONE;
                        else
                        begin
                            cnt      <= cnt + 1'b1;
                            cur_addr <= cur_addr + `DCP_DATA_W'(4);
                            state    <= D_READ;
                        end
                    end
                D_DONE:   state <= D_IDLE;
                default:  state <= D_IDLE;
            endcase
        end
    end

    // requests are single-cycle states
    assign io.req_rx  = (state == D_REQ_A);
    assign io.kind_rx = dcp_io_pkg::SCAN_HEX;
    assign io.req_tx  = (state == D_P_HEX) || (state == D_P_NL);
    assign io.kind_tx = (state == D_P_HEX) ? dcp_io_pkg::PRINT_HEX : dcp_io_pkg::PRINT_CHAR;
    assign io.dout_tx = (state == D_P_HEX) ? dout_dm : {{(`DCP_DATA_W-8){1'b0}}, `DCP_CHAR_NL};

    assign addr   = cur_addr;
    assign finish = (state == D_DONE);

    // outstanding requests, seen from this client
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            pend_rx <= 1'b0;
            pend_tx <= 1'b0;
        end
        else
        begin
            pend_rx <= io.req_rx || (pend_rx && !io.ack_rx);
            pend_tx <= io.req_tx || (pend_tx && !io.ack_tx);
        end
    end

    a_finish_clean: assert property (@(posedge clk) disable iff (rst)
        finish |-> !pend_rx && !pend_tx);

endmodule

`default_nettype wire

/* hdl/dcp_io_if.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dcp_cfg.svh"

// one client's path to the scan and print blocks
interface dcp_io_if;

    // requests, client to scan/print
    logic                       req_rx;
    dcp_io_pkg::scan_kind_e     kind_rx;
    logic                       req_tx;
    dcp_io_pkg::print_kind_e    kind_tx;
    logic [`DCP_DATA_W-1:0]     dout_tx;

    // answers, back from the request mux
    logic                       ack_rx;
    logic                       flag_rx;
    logic [`DCP_DATA_W-1:0]     din_rx;
    logic                       ack_tx;

    modport client (
        output req_rx, kind_rx, req_tx, kind_tx, dout_tx,
        input  ack_rx, flag_rx, din_rx, ack_tx
    );

    modport server (
        input  req_rx, kind_rx, req_tx, kind_tx, dout_tx,
        output ack_rx, flag_rx, din_rx, ack_tx
    );

endinterface

`default_nettype wire

/* hdl/dcp_io_pkg.sv */
`default_nettype none

package dcp_io_pkg;

    ////////////////////////////////////////////////////////////
    // request kinds for the shared scan and print blocks
    ////////////////////////////////////////////////////////////

    // scan returns one raw byte or an accumulated hex number
    typedef enum logic {
        SCAN_CHAR = 1'b0,
        SCAN_HEX  = 1'b1
    } scan_kind_e;

    // print sends one raw byte or eight hex digits
    typedef enum logic {
        PRINT_CHAR = 1'b0,
        PRINT_HEX  = 1'b1
    } print_kind_e;

endpackage

`default_nettype wire

/* hdl/dcp_print.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dcp_cfg.svh"

module dcp_print (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          req,
    input  wire dcp_io_pkg::print_kind_e kind,
    input  wire [`DCP_DATA_W-1:0]        data,
    output logic                         ack,
    output logic [7:0]                   d_tx,
    output logic                         vld_tx,
    input  wire                          rdy_tx
);

    localparam int DIGITS = `DCP_DATA_W / 4;
    localparam int CNT_W  = $clog2(DIGITS + 1);

    // upper-case hex digit
    function automatic logic [7:0] to_ascii(input logic [3:0] n);
        logic [7:0] r;
        if (n < 4'd10)
            r = 8'h30 + {4'b0, n};
        else
            r = 8'h37 + {4'b0, n};
        return r;
    endfunction

    logic [`DCP_DATA_W-1:0] word;
    logic [CNT_W-1:0]       left;
    logic                   pop;

    // byte leaves on this edge
    assign pop = vld_tx && rdy_tx;

    ////////////////////////////////////////////////////////////
    // digit counter and stream control
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            vld_tx <= 1'b0;
            ack    <= 1'b0;
            left   <= '0;
        end
        else
        begin
            ack <= 1'b0;
            if (req)
            begin
                vld_tx <= 1'b1;
                left   <= (kind == dcp_io_pkg::PRINT_HEX) ? CNT_W'(DIGITS) : CNT_W'(1);
            end
            else if (pop)
            begin
                left <= left - 1'b1;
                if (left == CNT_W'(1))
                begin
                    vld_tx <= 1'b0;
                    ack    <= 1'b1;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // output byte, msb nibble first
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (req)
        begin
            word <= data << 4;
            if (kind == dcp_io_pkg::PRINT_HEX)
                d_tx <= to_ascii(data[`DCP_DATA_W-1 -: 4]);
            else
                d_tx <= data[7:0];
        end
        else if (pop)
        begin
            word <= word << 4;
            d_tx <= to_ascii(word[`DCP_DATA_W-1 -: 4]);
        end
    end

    // a stalled byte stays put until taken
    a_hold_stall: assert property (@(posedge clk) disable iff (rst)
        vld_tx && !rdy_tx |=> vld_tx && $stable(d_tx));

endmodule

`default_nettype wire

/* hdl/dcp_scan.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dcp_cfg.svh"

module dcp_scan (
    input  wire                         clk,
    input  wire                         rst,
    input  wire [7:0]                   d_rx,
    input  wire                         vld_rx,
    output logic                        rdy_rx,
    input  wire                         req,
    input  wire dcp_io_pkg::scan_kind_e kind,
    output logic                        ack,
    output logic                        flag,
    output logic [`DCP_DATA_W-1:0]      value
);

    // msb marks a valid hex character
    function automatic logic [4:0] hex_digit(input logic [7:0] c);
        logic [4:0] r;
        r = 5'b0;
        // '0'..'9'
        if (c >= 8'h30 && c <= 8'h39)
            r = {1'b1, c[3:0]};
        // 'A'..'F' and 'a'..'f' share the low nibble
        else if ((c >= 8'h41 && c <= 8'h46) || (c >= 8'h61 && c <= 8'h66))
            r = {1'b1, c[3:0] + 4'd9};
        return r;
    endfunction

    dcp_io_pkg::scan_kind_e kind_q;
    logic [4:0]             dig;
    logic                   take;
    logic                   last;

    assign take = vld_rx && rdy_rx;
    assign dig  = hex_digit(d_rx);
    // a char request ends on any byte, a hex request on the first non-digit
    assign last = (kind_q == dcp_io_pkg::SCAN_CHAR) || !dig[4];

    ////////////////////////////////////////////////////////////
    // handshake
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            rdy_rx <= 1'b0;
            ack    <= 1'b0;
            flag   <= 1'b0;
        end
        else
        begin
            ack <= 1'b0;
            if (req)
            begin
                rdy_rx <= 1'b1;
                flag   <= 1'b0;
            end
            else if (take && last)
            begin
                rdy_rx <= 1'b0;
                ack    <= 1'b1;
                flag   <= (d_rx == `DCP_CHAR_NL);
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // accumulator
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (req)
        begin
            kind_q <= kind;
            value  <= '0;
        end
        else if (take)
        begin
            if (kind_q == dcp_io_pkg::SCAN_CHAR)
                value <= {{(`DCP_DATA_W-8){1'b0}}, d_rx};
            else if (dig[4])
                value <= {value[`DCP_DATA_W-5:0], dig[3:0]};
        end
    end

    // one request at a time per client
    a_req_when_idle: assert property (@(posedge clk) disable iff (rst) req |-> !rdy_rx);

endmodule

`default_nettype wire

/* hdl/dcp_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dcp_cfg.svh"

module dcp_top (
    input  wire                    clk,
    input  wire                    rst,
    input  wire [7:0]              d_rx,
    input  wire                    vld_rx,
    output logic                   rdy_rx,
    output logic [7:0]             d_tx,
    output logic                   vld_tx,
    input  wire                    rdy_tx,
    input  wire [`DCP_DATA_W-1:0]  pc,
    output logic [`DCP_DATA_W-1:0] addr,
    input  wire [`DCP_DATA_W-1:0]  dout_dm
);

    dcp_cmd_pkg::disp_state_e state;
    dcp_cmd_pkg::disp_state_e state_nx;
    logic                     scan_sent;
    logic [1:0]               p_step;

    // dispatcher's own requests
    logic                     disp_req_rx;
    logic                     disp_req_tx;
    dcp_io_pkg::print_kind_e  disp_kind_tx;
    logic [`DCP_DATA_W-1:0]   disp_dout_tx;
    logic                     disp_ack_rx;
    logic                     disp_ack_tx;

    // shared scan and print ports
    logic                     scan_req;
    dcp_io_pkg::scan_kind_e   scan_kind;
    logic                     scan_ack;
    logic                     scan_flag;
    logic [`DCP_DATA_W-1:0]   scan_value;
    logic                     print_req;
    dcp_io_pkg::print_kind_e  print_kind;
    logic [`DCP_DATA_W-1:0]   print_data;
    logic                     print_ack;

    logic                     dump_active;
    logic                     dump_finish;
    logic [`DCP_DATA_W-1:0]   dump_addr;

    dcp_io_if dump_io ();

    ////////////////////////////////////////////////////////////
    // dispatcher fsm
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        state_nx = state;
        case (state)
            dcp_cmd_pkg::INIT:    state_nx = dcp_cmd_pkg::REQ_1ST;
            dcp_cmd_pkg::REQ_1ST:
                if (disp_ack_rx)
                begin
                    case (scan_value[7:0])
                        dcp_cmd_pkg::CMD_P: state_nx = dcp_cmd_pkg::RUN_P;
                        dcp_cmd_pkg::CMD_D: state_nx = dcp_cmd_pkg::RUN_D;
                        // unknown command, read again
                        default:            state_nx = dcp_cmd_pkg::REQ_1ST;
                    endcase
                end
            dcp_cmd_pkg::RUN_P:
                if (p_step == 2'd3 && disp_ack_tx)
                    state_nx = dcp_cmd_pkg::INIT;
            dcp_cmd_pkg::RUN_D:   state_nx = dcp_cmd_pkg::WAIT;
            dcp_cmd_pkg::WAIT:
                if (dump_finish)
                    state_nx = dcp_cmd_pkg::INIT;
            default:              state_nx = dcp_cmd_pkg::INIT;
        endcase
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state     <= dcp_cmd_pkg::INIT;
            scan_sent <= 1'b0;
            p_step    <= 2'd0;
        end
        else
        begin
            state <= state_nx;
            // cleared on ack so a dropped character re-arms the scan
            scan_sent <= (state == dcp_cmd_pkg::REQ_1ST) && !disp_ack_rx;
            // 'P' steps: hex req, hex wait, newline req, newline wait
            if (state != dcp_cmd_pkg::RUN_P)
                p_step <= 2'd0;
            else if (!p_step[0] || disp_ack_tx)
                p_step <= p_step + 2'd1;
        end
    end

    assign disp_req_rx  = (state == dcp_cmd_pkg::REQ_1ST) && !scan_sent;
    assign disp_req_tx  = (state == dcp_cmd_pkg::RUN_P) && !p_step[0];
    assign disp_kind_tx = (p_step == 2'd0) ? dcp_io_pkg::PRINT_HEX : dcp_io_pkg::PRINT_CHAR;
    assign disp_dout_tx = (p_step == 2'd0) ? pc : {{(`DCP_DATA_W-8){1'b0}}, `DCP_CHAR_NL};

    ////////////////////////////////////////////////////////////
    // request mux
    ////////////////////////////////////////////////////////////

    assign dump_active = (state == dcp_cmd_pkg::RUN_D) || (state == dcp_cmd_pkg::WAIT);

    always_comb
    begin
        if (dump_active)
        begin
            scan_req   = dump_io.req_rx;
            scan_kind  = dump_io.kind_rx;
            print_req  = dump_io.req_tx;
            print_kind = dump_io.kind_tx;
            print_data = dump_io.dout_tx;
        end
        else
        begin
            scan_req   = disp_req_rx;
            scan_kind  = dcp_io_pkg::SCAN_CHAR;
            print_req  = disp_req_tx;
            print_kind = disp_kind_tx;
            print_data = disp_dout_tx;
        end
    end

    // acks reach only the owner
    assign dump_io.ack_rx  = scan_ack && dump_active;
    assign dump_io.ack_tx  = print_ack && dump_active;
    assign dump_io.flag_rx = scan_flag;
    assign dump_io.din_rx  = scan_value;
    assign disp_ack_rx     = scan_ack && !dump_active;
    assign disp_ack_tx     = print_ack && !dump_active;

    assign addr = dump_active ? dump_addr : '0;

    dcp_scan i_scan (
        .clk    (clk),
        .rst    (rst),
        .d_rx   (d_rx),
        .vld_rx (vld_rx),
        .rdy_rx (rdy_rx),
        .req    (scan_req),
        .kind   (scan_kind),
        .ack    (scan_ack),
        .flag   (scan_flag),
        .value  (scan_value)
    );

    dcp_print i_print (
        .clk    (clk),
        .rst    (rst),
        .req    (print_req),
        .kind   (print_kind),
        .data   (print_data),
        .ack    (print_ack),
        .d_tx   (d_tx),
        .vld_tx (vld_tx),
        .rdy_tx (rdy_tx)
    );

    dcp_dump i_dump (
        .clk     (clk),
        .rst     (rst),
        .start   (state == dcp_cmd_pkg::RUN_D),
        .io      (dump_io.client),
        .addr    (dump_addr),
        .dout_dm (dout_dm),
        .finish  (dump_finish)
    );

endmodule

`default_nettype wire

/* include/dcp_cfg.svh */
`ifndef DCP_CFG_SVH
`define DCP_CFG_SVH

////////////////////////////////////////////////////////////
// datapath sizes
////////////////////////////////////////////////////////////

// addresses, pc and memory words
`define DCP_DATA_W 32

// words printed by one 'D' command
`define DCP_DUMP_WORDS 4

////////////////////////////////////////////////////////////
// ascii codes used on the byte streams
////////////////////////////////////////////////////////////

// line end, also closes a hex number with flag set
`define DCP_CHAR_NL 8'h0A

// space, closes a hex number with flag clear
`define DCP_CHAR_SP 8'h20

`endif

/* tb.f */
+incdir+include
hdl/dcp_cmd_pkg.sv
hdl/dcp_io_pkg.sv
hdl/dcp_io_if.sv
hdl/dcp_scan.sv
hdl/dcp_print.sv
hdl/dcp_dump.sv
hdl/dcp_top.sv
verif/tb_dcp.sv

/* verif/tb_dcp.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dcp_cfg.svh"

module tb_dcp;

    localparam int N_DIRECTED      = 7;
    localparam int N_RANDOM        = 80;
    localparam int CYCLES_PER_CMD  = 300;
    localparam int WATCHDOG_CYCLES = (N_DIRECTED + N_RANDOM) * CYCLES_PER_CMD + 200;

    logic                   clk     = 1'b0;
    logic                   rst     = 1'b1;
    logic [7:0]             d_rx    = 8'h00;
    logic                   vld_rx  = 1'b0;
    logic                   rdy_rx;
    logic [7:0]             d_tx;
    logic                   vld_tx;
    logic                   rdy_tx  = 1'b0;
    logic [`DCP_DATA_W-1:0] pc      = '0;
    logic [`DCP_DATA_W-1:0] addr;
    logic [`DCP_DATA_W-1:0] dout_dm = '0;

    integer seed = 32'h68db8dca;

    // input bytes, and which of them is a 'P' that takes a new pc
    logic [7:0]             rx_q[$];
    bit                     rx_sets_pc[$];
    logic [`DCP_DATA_W-1:0] pc_q[$];
    // reply stream the DUT must produce
    logic [7:0]             exp_q[$];
    logic [`DCP_DATA_W-1:0] mem[logic [`DCP_DATA_W-1:0]];

    logic [`DCP_DATA_W-1:0] addr_q    = '0;
    logic                   stream_on = 1'b0;
    logic                   rx_taken  = 1'b0;
    logic                   tx_taken  = 1'b0;
    logic [7:0]             tx_byte   = 8'h00;
    logic [7:0]             exp_byte  = 8'h00;
    logic [31:0]            roll      = '0;

    dcp_top i_dcp_top (
        .clk     (clk),
        .rst     (rst),
        .d_rx    (d_rx),
        .vld_rx  (vld_rx),
        .rdy_rx  (rdy_rx),
        .d_tx    (d_tx),
        .vld_tx  (vld_tx),
        .rdy_tx  (rdy_tx),
        .pc      (pc),
        .addr    (addr),
        .dout_dm (dout_dm)
    );

    initial
    begin
        forever #4 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // reporting
    ////////////////////////////////////////////////////////////

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_val(input string name, input logic [31:0] expected,
                             input logic [31:0] got);
        if (expected !== got)
            abort_run($sformatf("mismatch %s expected=%h got=%h", name, expected, got));
    endtask

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    function automatic logic [7:0] hex_upper(input logic [3:0] n);
        if (n < 4'd10)
            return 8'h30 + {4'h0, n};
        else
            return 8'h41 + {4'h0, n} - 8'd10;
    endfunction

    // unwritten locations read back a pattern of their address
    function automatic logic [31:0] mem_word(input logic [31:0] a);
        if (mem.exists(a))
            return mem[a];
        else
            return {a[15:0], a[31:16]} ^ 32'h5AC3_3CA5;
    endfunction

    task automatic expect_word(input logic [31:0] w);
        int i;
        for (i = 7; i >= 0; i--)
            exp_q.push_back(hex_upper(w[4*i +: 4]));
        exp_q.push_back(`DCP_CHAR_NL);
    endtask

    task automatic send_byte(input logic [7:0] b, input bit sets_pc);
        rx_q.push_back(b);
        rx_sets_pc.push_back(sets_pc);
    endtask

    task automatic add_p_cmd();
        logic [31:0] v;
        v = $random(seed);
        pc_q.push_back(v);
        send_byte(8'h50, 1'b1);
        expect_word(v);
    endtask

    task automatic add_d_cmd(input logic [31:0] base, input int nd, input bit use_nl);
        logic [3:0]  n;
        logic [7:0]  c;
        logic [31:0] a;
        logic [31:0] pick;
        int          i;
        send_byte(8'h44, 1'b0);
        for (i = nd - 1; i >= 0; i--)
        begin
            n    = base[4*i +: 4];
            pick = $random(seed);
            // letters go out in either case
            if (n >= 4'd10 && pick[0])
                c = 8'h61 + {4'h0, n} - 8'd10;
            else
                c = hex_upper(n);
            send_byte(c, 1'b0);
        end
        send_byte(use_nl ? `DCP_CHAR_NL : `DCP_CHAR_SP, 1'b0);
        for (i = 0; i < `DCP_DUMP_WORDS; i++)
        begin
            a = base + 32'(4 * i);
            if (!mem.exists(a))
                mem[a] = $random(seed);
            expect_word(mem[a]);
        end
    endtask

    task automatic add_random_cmd();
        logic [31:0] r;
        logic [31:0] base;
        logic [63:0] mask;
        logic [7:0]  b;
        int          nd;
        r = $random(seed);
        case (r[1:0])
            2'd0: add_p_cmd();
            2'd3:
            begin
                b = r[15:8];
                // lower-case 'p' and 'd' are not commands
                if (b == 8'h50 || b == 8'h44)
                    b = b ^ 8'h20;
                send_byte(b, 1'b0);
            end
            default:
            begin
                nd   = int'(r[4:2]) + 1;
                mask = (64'd1 << (4 * nd)) - 64'd1;
                base = $random(seed);
                base = base & mask[31:0];
                add_d_cmd(base, nd, r[5]);
            end
        endcase
    endtask

    ////////////////////////////////////////////////////////////
    // falling-edge drivers, memory model and output monitor
    ////////////////////////////////////////////////////////////

    always @(negedge clk)
    begin
        // synchronous read of last cycle's address
        dout_dm = mem_word(addr_q);
        addr_q  = addr;
        if (!rst)
        begin
            if (rx_taken)
            begin
                if (rx_sets_pc.pop_front())
                    pc = pc_q.pop_front();
                void'(rx_q.pop_front());
                vld_rx = 1'b0;
            end
            if (stream_on && rx_q.size() != 0 && !vld_rx)
            begin
                roll = $random(seed);
                // idle gap about one cycle in four
                if (roll[1:0] != 2'b00)
                begin
                    d_rx   = rx_q[0];
                    vld_rx = 1'b1;
                end
            end
            rx_taken = vld_rx && rdy_rx;

            if (tx_taken)
            begin
                if (exp_q.size() == 0)
                    abort_run($sformatf("output byte %h appeared with no reply pending",
                                        tx_byte));
                else
                begin
                    exp_byte = exp_q.pop_front();
                    check_val("d_tx", 32'(exp_byte), 32'(tx_byte));
                end
            end
            roll     = $random(seed);
            // back-pressure on d_tx
            rdy_tx   = (roll[1:0] != 2'b00);
            tx_taken = vld_tx && rdy_tx;
            tx_byte  = d_tx;
        end
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        abort_run($sformatf("timeout: output stalled with %0d reply bytes never sent",
                            exp_q.size()));
    end

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////

    initial
    begin
        int k;
        // directed commands first and then a random mix
        add_p_cmd();
        add_d_cmd(32'hC0FFEE10, 8, 1'b0);
        add_d_cmd(32'h0BADF00D, 7, 1'b1);
        send_byte(8'h78, 1'b0);
        send_byte(`DCP_CHAR_NL, 1'b0);
        add_p_cmd();
        add_d_cmd(32'h00000A5C, 3, 1'b1);
        for (k = 0; k < N_RANDOM; k++)
            add_random_cmd();

        repeat (5)
        begin
            @(negedge clk);
            check_val("rdy_rx", 32'd0, 32'(rdy_rx));
            check_val("vld_tx", 32'd0, 32'(vld_tx));
        end
        rst = 1'b0;

        // nothing may come out before any input
        repeat (20)
        begin
            @(negedge clk);
            check_val("vld_tx", 32'd0, 32'(vld_tx));
        end

        stream_on = 1'b1;
        while (rx_q.size() != 0 || exp_q.size() != 0)
            @(negedge clk);

        // quiet after the last reply
        repeat (50)
        begin
            @(negedge clk);
            check_val("vld_tx", 32'd0, 32'(vld_tx));
        end

        // memory address parks at zero once the dump is over
        check_val("addr", 32'd0, addr);

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire
